// File: src/dcache_consts.svh
/*
 * Data cache geometry and memory credit count.
 * Shared by the package and every cache block.
 */

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Number of ways in each set
`define DC_WAYS 4

// Number of sets, indexed by the low bits of the line address
`define DC_SETS 16

// One line is four 32-bit words
`define DC_LINE_BITS 128

// Request slots the memory side grants at reset
`define DC_MEM_CREDITS 2

`endif

// File: src/dcache_pkg.sv
/*
 * Data cache types.
 * Address layout, load request and memory channel payloads.
 */

`include "dcache_consts.svh"

package dcache_pkg;

  // ======================================
  // Load side
  // ======================================

  // Byte address split at the line and word boundaries
  // The low 4 bits of line_adr select the set
  typedef struct packed {
    logic [27:0] line_adr;
    logic [1:0]  word;
    logic [1:0]  byte_sel;
  } dc_adr_t;

  // A load request carries only its address
  typedef struct packed {
    dc_adr_t adr;
  } dc_req_t;

  // ======================================
  // Memory side
  // ======================================

  // Line-fill request, one whole line per request
  typedef struct packed {
    logic [27:0] line_adr;
  } mem_req_t;

  // Returned line, word 0 sits in the low bits
  typedef struct packed {
    logic [`DC_LINE_BITS-1:0] line;
  } mem_rsp_t;

  // Way number within a set
  typedef logic [1:0] dc_way_t;

endpackage

// File: src/dcache_hit.sv
/*
 * Four-way hit detector.
 * Compares every way's stored line address in parallel and picks the
 * lowest hitting way, holding the last way when nothing hits.
 */

`include "dcache_consts.svh"

module dcache_hit (
  input  logic                                   clk,
  input  dcache_pkg::dc_adr_t [`DC_WAYS-1:0]     tags,
  input  logic [`DC_WAYS-1:0]                    valid,
  input  dcache_pkg::dc_adr_t                    adr,
  output logic [`DC_WAYS-1:0]                    hits,
  output logic                                   hit,
  output dcache_pkg::dc_way_t                    rway
);

  import dcache_pkg::*;

  // Way chosen on the previous cycle
  dc_way_t prev_rway;

  // A way hits only if its entry is valid and the line addresses agree
  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      hits[w] = valid[w] && (tags[w].line_adr == adr.line_adr);
    end
  end

  assign hit = |hits;

  // Walk from the top way down so the lowest hitting way wins
  always_comb
  begin
    rway = prev_rway;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      if (hits[w])
        rway = dc_way_t'(w);
    end
  end

  always_ff @(posedge clk)
  begin
    prev_rway <= rway;
  end

endmodule

// File: src/dcache_tags.sv
/*
 * Tag and valid storage for the data cache.
 * Holds a line address and valid bit per way and set, and a round-robin
 * victim counter per set that advances on every fill.
 */

`include "dcache_consts.svh"

module dcache_tags (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  dcache_pkg::dc_adr_t                    adr,
  input  logic                                   fill,
  input  logic                                   inv,
  output dcache_pkg::dc_adr_t [`DC_WAYS-1:0]     tags,
  output logic [`DC_WAYS-1:0]                    valid,
  output dcache_pkg::dc_way_t                    victim
);

  import dcache_pkg::*;

  localparam int SET_W = $clog2(`DC_SETS);

  // Stored line addresses, one array per way
  logic [27:0]              line_mem [`DC_WAYS][`DC_SETS];

  // One valid bit per set for each way
  logic [`DC_SETS-1:0]      valid_q [`DC_WAYS];

  // Next way to replace in each set
  dc_way_t                  rr_q [`DC_SETS];

  logic [SET_W-1:0]         set_idx;

  assign set_idx = adr.line_adr[SET_W-1:0];

  // ======================================
  // Read side
  // ======================================

  // Word and byte fields of a stored tag are always zero
  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      tags[w].line_adr = line_mem[w][set_idx];
      tags[w].word     = 2'b00;
      tags[w].byte_sel = 2'b00;
      valid[w]         = valid_q[w][set_idx];
    end
  end

  assign victim = rr_q[set_idx];

  // ======================================
  // Write side
  // ======================================

  // The filled line lands in whichever way the set's counter points at
  always_ff @(posedge clk)
  begin
    if (fill)
      line_mem[victim][set_idx] <= adr.line_adr;
  end

  // Invalidate wins over a fill, though the controller never asks for both
  always_ff @(posedge clk)
  begin
    if (!rst_n || inv)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
        valid_q[w] <= '0;
    end
    else if (fill)
      valid_q[victim][set_idx] <= 1'b1;
  end

  // Counters survive an invalidate and only restart on reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < `DC_SETS; s++)
        rr_q[s] <= '0;
    end
    else if (fill)
      rr_q[set_idx] <= rr_q[set_idx] + 2'd1;
  end

endmodule

// File: src/dcache_data.sv
/*
 * Line storage for the data cache.
 * Reads one word by way, set and word offset, and writes a whole
 * returned line into the fill way.
 */

`include "dcache_consts.svh"

module dcache_data (
  input  logic                  clk,
  input  dcache_pkg::dc_adr_t   adr,
  input  dcache_pkg::dc_way_t   rway,
  input  logic                  fill,
  input  dcache_pkg::dc_way_t   fill_way,
  input  dcache_pkg::mem_rsp_t  fill_line,
  output logic [31:0]           rd_word
);

  localparam int SET_W = $clog2(`DC_SETS);

  // One full line per way and set
  logic [`DC_LINE_BITS-1:0] line_mem [`DC_WAYS][`DC_SETS];

  logic [SET_W-1:0]         set_idx;
  logic [`DC_LINE_BITS-1:0] rd_line;

  assign set_idx = adr.line_adr[SET_W-1:0];

  // ======================================
  // Read mux
  // ======================================

  // First pick the line of the hitting way, then the word inside it
  assign rd_line = line_mem[rway][set_idx];
  assign rd_word = rd_line[{adr.word, 5'b00000} +: 32];

  // ======================================
  // Fill write
  // ======================================

  // The fill address is the same lookup address the tags see
  always_ff @(posedge clk)
  begin
    if (fill)
      line_mem[fill_way][set_idx] <= fill_line.line;
  end

endmodule

// File: src/dcache_ctrl.sv
/*
 * Data cache controller.
 * Latches accepted loads, looks them up the cycle after, and runs a
 * single outstanding line fill under credit-based flow control.
 */

`include "dcache_consts.svh"

module dcache_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  dcache_pkg::dc_req_t   req,
  output logic                  rsp_valid,
  output dcache_pkg::dc_adr_t   lookup_adr,
  input  logic                  hit,
  output logic                  fill,
  input  logic                  inv,
  output logic                  inv_en,
  output logic                  mem_req_valid,
  output dcache_pkg::mem_req_t  mem_req,
  input  logic                  mem_credit,
  input  logic                  mem_rsp_valid
);

  import dcache_pkg::*;

  localparam int CRED_W = $clog2(`DC_MEM_CREDITS + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MISS_CRED,
    ST_MISS_DATA,
    ST_RESP
  } state_t;

  state_t             state;
  logic               pend_q;
  dc_adr_t            adr_q;
  logic [CRED_W-1:0]  credits;
  logic               accept;
  logic               have_credit;
  logic               miss_now;

  // ======================================
  // Handshake and lookup
  // ======================================

  assign accept      = req_valid && req_ready;
  assign have_credit = (credits != '0);

  // A load accepted last cycle is being looked up now
  assign miss_now    = (state == ST_IDLE) && pend_q && !hit;

  // Ready drops in the lookup cycle of a miss and stays low until the fill
  // has been turned into a response
  assign req_ready = ((state == ST_IDLE) && !miss_now) || (state == ST_RESP);

  // Hits answer in the lookup cycle, misses one cycle after the fill
  assign rsp_valid = ((state == ST_IDLE) && pend_q && hit) || (state == ST_RESP);

  assign lookup_adr = adr_q;

  // Invalidate only when no load is in flight
  assign inv_en = inv && (state == ST_IDLE) && !pend_q;

  // The returned line is written in the cycle it arrives
  assign fill = (state == ST_MISS_DATA) && mem_rsp_valid;

  // ======================================
  // Memory request
  // ======================================

  // The request goes out in the lookup cycle itself if a credit is on hand
  assign mem_req_valid    = (miss_now || (state == ST_MISS_CRED)) && have_credit;
  assign mem_req.line_adr = adr_q.line_adr;

  // Address of the load in flight
  always_ff @(posedge clk)
  begin
    if (accept)
      adr_q <= req.adr;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pend_q <= 1'b0;
    else
      pend_q <= accept;
  end

  // ======================================
  // State machine
  // ======================================

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:
        begin
          // Without a credit the miss parks until one comes back
          if (miss_now)
            state <= have_credit ? ST_MISS_DATA : ST_MISS_CRED;
        end
        ST_MISS_CRED:
        begin
          if (have_credit)
            state <= ST_MISS_DATA;
        end
        ST_MISS_DATA:
        begin
          if (mem_rsp_valid)
            state <= ST_RESP;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ======================================
  // Credit counter
  // ======================================

  // A request and a returning credit in the same cycle cancel out
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      credits <= CRED_W'(`DC_MEM_CREDITS);
    else
    begin
      case ({mem_req_valid, mem_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: src/dcache_top.sv
/*
 * Four-way set-associative read data cache.
 * Joins the controller, tag store, hit detector and line store.
 */

`include "dcache_consts.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  dcache_pkg::dc_req_t   req,
  output logic                  rsp_valid,
  output logic [31:0]           rsp_data,
  input  logic                  inv,
  output logic                  mem_req_valid,
  output dcache_pkg::mem_req_t  mem_req,
  input  logic                  mem_credit,
  input  logic                  mem_rsp_valid,
  input  dcache_pkg::mem_rsp_t  mem_rsp
);

  import dcache_pkg::*;

  dc_adr_t                  lookup_adr;
  dc_adr_t [`DC_WAYS-1:0]   tags;
  logic [`DC_WAYS-1:0]      valid;
  dc_way_t                  victim;
  dc_way_t                  rway;
  logic                     hit;
  logic                     fill;
  logic                     inv_en;

  dcache_ctrl u_dcache_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .lookup_adr    (lookup_adr),
    .hit           (hit),
    .fill          (fill),
    .inv           (inv),
    .inv_en        (inv_en),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid)
  );

  dcache_tags u_dcache_tags (
    .clk    (clk),
    .rst_n  (rst_n),
    .adr    (lookup_adr),
    .fill   (fill),
    .inv    (inv_en),
    .tags   (tags),
    .valid  (valid),
    .victim (victim)
  );

  // One-hot hits stay inside the detector, only the way number is needed
  dcache_hit u_dcache_hit (
    .clk   (clk),
    .tags  (tags),
    .valid (valid),
    .adr   (lookup_adr),
    .hits  (),
    .hit   (hit),
    .rway  (rway)
  );

  // The victim way of the tag store is also where the data lands
  dcache_data u_dcache_data (
    .clk       (clk),
    .adr       (lookup_adr),
    .rway      (rway),
    .fill      (fill),
    .fill_way  (victim),
    .fill_line (mem_rsp),
    .rd_word   (rsp_data)
  );

endmodule

// File: bench/dcache_props.sv
/*
 * Bound checker for the data cache.
 * Rebuilds cache residency from port activity alone and checks data,
 * hit and miss behavior, credits, replacement, invalidate and handshake.
 */

`include "dcache_consts.svh"

module dcache_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req_valid,
  input logic                  req_ready,
  input dcache_pkg::dc_req_t   req,
  input logic                  rsp_valid,
  input logic [31:0]           rsp_data,
  input logic                  inv,
  input logic                  mem_req_valid,
  input dcache_pkg::mem_req_t  mem_req,
  input logic                  mem_credit,
  input logic                  mem_rsp_valid
);

  import dcache_pkg::*;

  localparam int SET_W = $clog2(`DC_SETS);

  // Count of failed assertions
  int fail_cnt = 0;

  // Shadow residency holds one line address and valid bit per way and set
  logic [27:0]          sh_line [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0]  sh_valid [`DC_SETS];
  dc_way_t              sh_rr [`DC_SETS];

  dc_adr_t              last_adr;
  logic                 look_q;
  logic                 miss_q;
  logic                 sent_q;
  logic                 resp_q;
  logic                 rst_q;
  logic                 evict_v;
  logic                 inv_v;
  logic [27:0]          evict_line;
  logic [27:0]          inv_line;
  int                   out_q;
  int                   cred_q;
  logic                 accept;
  logic                 sh_hit;
  logic                 filling;
  logic                 inv_ok;
  logic [SET_W-1:0]     set_idx;
  logic [31:0]          word_adr;
  logic [31:0]          exp_word;

  assign accept  = req_valid && req_ready;
  assign set_idx = last_adr.line_adr[SET_W-1:0];
  assign filling = mem_rsp_valid && miss_q && sent_q;

  // An invalidate only counts while no load is outstanding
  assign inv_ok  = inv && (out_q == 0);

  // Every word holds its own byte address rotated left by 8
  assign word_adr = {last_adr.line_adr, last_adr.word, 2'b00};
  assign exp_word = {word_adr[23:0], word_adr[31:24]};

  always_comb
  begin
    sh_hit = 1'b0;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (sh_valid[set_idx][w] && (sh_line[w][set_idx] == last_adr.line_adr))
        sh_hit = 1'b1;
    end
  end

  // ========================================
  // Shadow model
  // ========================================

  always_ff @(posedge clk)
  begin
    rst_q <= !rst_n;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      last_adr <= '0;
      look_q   <= 1'b0;
      miss_q   <= 1'b0;
      sent_q   <= 1'b0;
      resp_q   <= 1'b0;
      evict_v  <= 1'b0;
      inv_v    <= 1'b0;
      out_q    <= 0;
      cred_q   <= `DC_MEM_CREDITS;
      for (int s = 0; s < `DC_SETS; s++)
      begin
        sh_valid[s] <= '0;
        sh_rr[s]    <= '0;
      end
    end
    else
    begin
      look_q <= accept;
      resp_q <= filling;
      out_q  <= out_q + int'(accept) - int'(rsp_valid);
      cred_q <= cred_q - int'(mem_req_valid) + int'(mem_credit);
      if (accept)
        last_adr <= req.adr;
      // A miss is open from its lookup until its line arrives
      if (look_q && !sh_hit)
        miss_q <= 1'b1;
      else if (filling)
        miss_q <= 1'b0;
      if (mem_req_valid)
        sent_q <= 1'b1;
      else if (filling)
        sent_q <= 1'b0;
      if (filling)
      begin
        // A refilled line is no longer the evicted or invalidated one
        if (evict_line == last_adr.line_adr)
          evict_v <= 1'b0;
        if (inv_line == last_adr.line_adr)
          inv_v <= 1'b0;
        if (sh_valid[set_idx][sh_rr[set_idx]])
        begin
          evict_v    <= 1'b1;
          evict_line <= sh_line[sh_rr[set_idx]][set_idx];
        end
        sh_line[sh_rr[set_idx]][set_idx]  <= last_adr.line_adr;
        sh_valid[set_idx][sh_rr[set_idx]] <= 1'b1;
        sh_rr[set_idx]                    <= sh_rr[set_idx] + 2'd1;
      end
      // The line touched last was resident when the invalidate hit
      if (inv_ok)
      begin
        for (int s = 0; s < `DC_SETS; s++)
          sh_valid[s] <= '0;
        inv_v    <= 1'b1;
        inv_line <= last_adr.line_adr;
      end
    end
  end

  // ========================================
  // Checks
  // ========================================

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_data == exp_word)
    else
    begin
      $error("Fail data: expected %h, got %h", exp_word, rsp_data);
      fail_cnt++;
    end

  // Hits answer in the lookup cycle and misses stall the port
  a_lookup: assert property (@(posedge clk) disable iff (!rst_n)
    look_q |-> (rsp_valid == sh_hit) && (req_ready == sh_hit))
    else
    begin
      $error("lookup of line %h disagrees with residency", last_adr.line_adr);
      fail_cnt++;
    end

  a_mem_req: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid |-> (miss_q || (look_q && !sh_hit)) && !sent_q
                      && (mem_req.line_adr == last_adr.line_adr))
    else
    begin
      $error("memory request %h without a matching open miss", mem_req.line_adr);
      fail_cnt++;
    end

  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (cred_q <= `DC_MEM_CREDITS) && (!mem_req_valid || (cred_q > 0)))
    else
    begin
      $error("credit count %0d broken by a memory request", cred_q);
      fail_cnt++;
    end

  a_evict: assert property (@(posedge clk) disable iff (!rst_n)
    look_q && evict_v && (last_adr.line_adr == evict_line) |-> !rsp_valid && !req_ready)
    else
    begin
      $error("evicted line %h still hit", evict_line);
      fail_cnt++;
    end

  a_inv: assert property (@(posedge clk) disable iff (!rst_n)
    look_q && inv_v && (last_adr.line_adr == inv_line) |-> !rsp_valid)
    else
    begin
      $error("line %h hit after an invalidate", inv_line);
      fail_cnt++;
    end

  // Each accepted load gets one response from its lookup or its finished fill
  a_resp: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> (out_q == 1) && (look_q || resp_q))
    else
    begin
      $error("response with %0d loads outstanding", out_q);
      fail_cnt++;
    end

  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (!miss_q || !req_ready) && (!resp_q || (rsp_valid && req_ready)))
    else
    begin
      $error("ready or response wrong around a miss");
      fail_cnt++;
    end

  a_reset: assert property (@(posedge clk) disable iff (!rst_n)
    rst_q |-> !rsp_valid && !mem_req_valid && req_ready)
    else
    begin
      $error("outputs not at their reset values");
      fail_cnt++;
    end

endmodule

// File: bench/dcache_tb.sv
/*
 * Testbench for the four-way data cache.
 * Drives LFSR-picked and scripted loads, models a credit-based line
 * memory with late credits, and sums up the bound assertion results.
 */

module dcache_tb;

  import dcache_pkg::*;

  localparam int N_RAND  = 40;
  // Random loads plus six replacement loads and three invalidate loads
  localparam int N_REQ   = N_RAND + 9;
  localparam int TIMEOUT = 200 * N_REQ;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  dc_req_t     req;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        inv;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_credit;
  logic        mem_rsp_valid;
  mem_rsp_t    mem_rsp;

  logic [31:0] lfsr = 32'ha7eb_6649;
  int          errors = 0;
  int          sent = 0;
  int          rcvd = 0;
  int          cyc = 0;
  int          rsp_wait = 0;
  logic [27:0] mem_q [$];
  int          credit_due [$];

  always #4 clk = ~clk;

  dcache_top u_dcache_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .inv           (inv),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp)
  );

  bind dcache_top dcache_props u_dcache_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .inv           (inv),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid)
  );

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit handed out
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Sets 0 to 3 get eight lines each, which is twice what a set can hold
  function automatic dc_adr_t pool_adr(input logic [31:0] r);
    dc_adr_t a;
    a.line_adr = {24'h012340 + 24'(r[8:6]), 2'b00, r[5:4]};
    a.word     = r[3:2];
    a.byte_sel = r[1:0];
    return a;
  endfunction

  // Lines reserved for set 15, which the random pool never touches
  function automatic dc_adr_t set15_adr(input int t);
    dc_adr_t a;
    a.line_adr = {24'h055000 + 24'(t), 4'hf};
    a.word     = 2'(t);
    a.byte_sel = 2'b00;
    return a;
  endfunction

  // Each word is its own byte address rotated left by 8
  function automatic mem_rsp_t line_data(input logic [27:0] line_adr);
    mem_rsp_t    r;
    logic [31:0] b;
    for (int i = 0; i < 4; i++)
    begin
      b                  = {line_adr, 2'(i), 2'b00};
      r.line[32*i +: 32] = {b[23:0], b[31:24]};
    end
    return r;
  endfunction

  // Present one load and hold it until the cache takes it
  task automatic send(input dc_adr_t a);
    req_valid <= 1'b1;
    req.adr   <= a;
    do
      @(negedge clk);
    while (!req_ready);
    @(posedge clk);
    sent++;
  endtask

  task automatic drain();
    req_valid <= 1'b0;
    do
      @(negedge clk);
    while (rcvd < sent);
    @(posedge clk);
  endtask

  task automatic invalidate();
    inv <= 1'b1;
    @(posedge clk);
    inv <= 1'b0;
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
      $display("Fail %s: expected %0d, got %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_run();
    int afails;
    afails = u_dcache_top.u_dcache_props.fail_cnt;
    $display("Summary: %0d errors, %0d assertion failures", errors, afails);
    if (errors == 0 && afails == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  // ========================================
  // Memory model and monitors
  // ========================================

  always @(negedge clk)
  begin
    if (rst_n && rsp_valid)
      rcvd <= rcvd + 1;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // Lines come back after 1 to 8 cycles and credits only after 16 to 47
  initial
  begin
    logic [31:0] r;
    mem_credit    <= 1'b0;
    mem_rsp_valid <= 1'b0;
    mem_rsp       <= '0;
    forever
    begin
      @(negedge clk);
      if (rst_n && mem_req_valid)
      begin
        mem_q.push_back(mem_req.line_adr);
        take_bits(3, r);
        rsp_wait = 1 + int'(r[2:0]);
        take_bits(5, r);
        credit_due.push_back(cyc + 16 + int'(r[4:0]));
      end
      @(posedge clk);
      mem_rsp_valid <= 1'b0;
      mem_credit    <= 1'b0;
      if (mem_q.size() > 0)
      begin
        if (rsp_wait == 0)
        begin
          mem_rsp_valid <= 1'b1;
          mem_rsp       <= line_data(mem_q.pop_front());
        end
        else
          rsp_wait--;
      end
      if (credit_due.size() > 0 && cyc >= credit_due[0])
      begin
        mem_credit <= 1'b1;
        credit_due.delete(0);
      end
    end
  end

  initial
  begin
    while (cyc < TIMEOUT)
      @(negedge clk);
    $display("Timeout after %0d cycles with %0d of %0d responses", cyc, rcvd, sent);
    errors++;
    finish_run();
  end

  // ========================================
  // Stimulus
  // ========================================

  initial
  begin
    logic [31:0] r;
    rst_n     <= 1'b0;
    req_valid <= 1'b0;
    req       <= '0;
    inv       <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Random loads fill, hit and evict across four busy sets
    for (int i = 0; i < N_RAND; i++)
    begin
      take_bits(9, r);
      send(pool_adr(r));
    end
    drain();

    // The fifth line replaces the first, so the first misses again
    for (int t = 0; t < 5; t++)
      send(set15_adr(t));
    send(set15_adr(0));
    drain();

    // A resident line, hit back to back, misses after the invalidate
    send(set15_adr(3));
    send(set15_adr(3));
    drain();
    invalidate();
    send(set15_adr(3));
    drain();

    repeat (8) @(posedge clk);
    check_count("responses", sent, rcvd);
    finish_run();
  end

endmodule

// File: list.f
+incdir+src
src/dcache_pkg.sv
src/dcache_hit.sv
src/dcache_tags.sv
src/dcache_data.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_props.sv
bench/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Build the data cache testbench with Verilator, run it and look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f list.f \
  && ./obj_dir/Vdcache_tb +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
